// File: flist.f
+incdir+common
common/periph_pkg.sv
src/iob_split.sv
boot_ctr/boot_ctr.sv
clint/clint_timer.sv
clint/clint_regs.sv
src/periph_sys.sv
verif/tb_periph_sys.sv

// File: Bender.yml
package:
  name: periph_sys

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/periph_pkg.sv
      - src/iob_split.sv
      - boot_ctr/boot_ctr.sv
      - clint/clint_timer.sv
      - clint/clint_regs.sv
      - src/periph_sys.sv
  - target: test
    include_dirs:
      - common
    files:
      - verif/tb_periph_sys.sv

// File: verif/tb_periph_sys.sv
`timescale 1ns/1ps
`default_nettype none

`include "periph_params.svh"

module tb_periph_sys
  import periph_pkg::*;
;

  localparam int BusWaitLimit   = 100;
  localparam int PulseWaitLimit = 4 * `CPU_RST_CYCLES;
  localparam int IrqWaitLimit   = 400;

  logic        clk;
  logic        arst_n;
  iob_req_t    bus_req;
  iob_resp_t   bus_resp;
  logic        boot;
  logic        cpu_reset;
  logic        timer_irq;
  logic        soft_irq;
  int unsigned cycle_cnt = 0;

  periph_sys i_periph_sys (
    .clk_i      (clk),
    .arst_n_i   (arst_n),
    .bus_req_i  (bus_req),
    .bus_resp_o (bus_resp),
    .boot_o     (boot),
    .cpu_reset_o(cpu_reset),
    .timer_irq_o(timer_irq),
    .soft_irq_o (soft_irq)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Free-running cycle count read at falling edges
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  task automatic stop_on_failure();
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic report_problem(input string why);
    $display("%s", why);
    stop_on_failure();
  endtask

  task automatic check_val(input string test, input logic [31:0] expected,
                           input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("error %s: expected 0x%08h, actual 0x%08h", test, expected, actual);
      stop_on_failure();
    end
  endtask

  task automatic range_check(input string test, input logic [31:0] lo,
                             input logic [31:0] hi, input logic [31:0] actual);
    assert (actual >= lo && actual <= hi) else begin
      $display("error %s: expected 0x%08h..0x%08h, actual 0x%08h", test, lo, hi, actual);
      stop_on_failure();
    end
  endtask

  function automatic logic [`PERIPH_ADDR_W-1:0] make_addr(input int slot,
                                                          input logic [7:0] offs);
    logic [`PERIPH_ADDR_W-1:0] a;
    a = '0;
    a[`PERIPH_ADDR_W-1 -: `PERIPH_SEL_W] = slot[`PERIPH_SEL_W-1:0];
    a[`PERIPH_OFFS_W-1:0] = offs;
    return a;
  endfunction

  // Returns on the accepting rising edge
  task automatic wait_accept(input string who);
    int n;
    n = 0;
    @(negedge clk);
    assert (bus_resp.rvalid === 1'b0) else report_problem({who, ": rvalid without a read"});
    while (bus_resp.ready !== 1'b1) begin
      n++;
      if (n > BusWaitLimit) begin
        report_problem({who, ": request was never accepted"});
      end
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  task automatic bus_write(input logic [`PERIPH_ADDR_W-1:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    iob_req_t req;
    req        = '0;
    req.avalid = 1'b1;
    req.addr   = addr;
    req.wdata  = data;
    req.wstrb  = strb;
    @(posedge clk);
    bus_req <= req;
    wait_accept("bus_write");
    bus_req <= '0;
  endtask

  task automatic bus_read(input logic [`PERIPH_ADDR_W-1:0] addr, output logic [31:0] data);
    iob_req_t req;
    req        = '0;
    req.avalid = 1'b1;
    req.addr   = addr;
    @(posedge clk);
    bus_req <= req;
    wait_accept("bus_read");
    bus_req <= '0;
    @(negedge clk);
    assert (bus_resp.rvalid === 1'b1) else begin
      report_problem("bus_read: no rvalid one cycle after acceptance");
    end
    data = bus_resp.rdata;
  endtask

  // Counts falling edges with cpu_reset high
  task automatic measure_reset_pulse(output int n);
    n = 0;
    while (cpu_reset === 1'b1) begin
      n++;
      if (n > PulseWaitLimit) begin
        report_problem("cpu_reset stuck high");
      end
      @(negedge clk);
    end
  endtask

  task automatic reset_values();
    int n;
    @(negedge clk);
    check_val("reset boot", 32'd1, 32'(boot));
    check_val("reset cpu_reset", 32'd1, 32'(cpu_reset));
    check_val("reset timer_irq", 32'd0, 32'(timer_irq));
    check_val("reset soft_irq", 32'd0, 32'(soft_irq));
    measure_reset_pulse(n);
    check_val("reset pulse length", 32'(`CPU_RST_CYCLES), 32'(n));
  endtask

  task automatic boot_control();
    logic [`PERIPH_ADDR_W-1:0] ctrl;
    logic [31:0] d;
    int n;
    ctrl = make_addr(`SLV_BOOT_CTR, 8'h00);
    bus_write(ctrl, 32'h0, 4'hf);
    @(negedge clk);
    check_val("boot clear", 32'd0, 32'(boot));
    bus_read(ctrl, d);
    check_val("boot readback", 32'h0, d);
    // Software reset request and its pulse length
    bus_write(ctrl, 32'h2, 4'hf);
    @(negedge clk);
    measure_reset_pulse(n);
    check_val("cpu reset pulse", 32'(`CPU_RST_CYCLES), 32'(n));
    check_val("boot kept", 32'd0, 32'(boot));
    // Status bit during a second request
    bus_write(ctrl, 32'h2, 4'hf);
    bus_read(ctrl, d);
    check_val("reset status", 32'h2, d);
    measure_reset_pulse(n);
    bus_read(ctrl, d);
    check_val("reset status done", 32'h0, d);
    bus_write(ctrl, 32'h1, 4'hf);
    bus_read(ctrl, d);
    check_val("boot restore", 32'h1, d);
  endtask

  task automatic soft_interrupt();
    logic [`PERIPH_ADDR_W-1:0] msip;
    logic [31:0] d;
    msip = make_addr(`SLV_CLINT, CLINT_MSIP);
    bus_write(msip, 32'h1, 4'hf);
    @(negedge clk);
    check_val("soft_irq set", 32'd1, 32'(soft_irq));
    bus_read(msip, d);
    check_val("msip readback", 32'h1, d);
    bus_write(msip, 32'h0, 4'hf);
    @(negedge clk);
    check_val("soft_irq clear", 32'd0, 32'(soft_irq));
    bus_read(msip, d);
    check_val("msip cleared", 32'h0, d);
  endtask

  task automatic timer_compare();
    logic [31:0] v;
    logic [31:0] d;
    int unsigned t0;
    v = $urandom & 32'h0000_ffff;
    bus_write(make_addr(`SLV_CLINT, CLINT_MTIME_HI), 32'h0, 4'hf);
    bus_write(make_addr(`SLV_CLINT, CLINT_MTIME_LO), v, 4'hf);
    @(negedge clk);
    t0 = cycle_cnt;
    bus_read(make_addr(`SLV_CLINT, CLINT_MTIME_LO), d);
    range_check("mtime load", v, v + (cycle_cnt - t0), d);
    bus_write(make_addr(`SLV_CLINT, CLINT_MTIMECMP_HI), 32'h0, 4'hf);
    bus_write(make_addr(`SLV_CLINT, CLINT_MTIMECMP_LO), v + 32'd200, 4'hf);
    @(negedge clk);
    check_val("timer_irq early", 32'd0, 32'(timer_irq));
    while (timer_irq !== 1'b1) begin
      if (cycle_cnt - t0 > IrqWaitLimit) begin
        report_problem("timer_irq never rose");
      end
      @(negedge clk);
    end
    // Compare seen one cycle after mtime reaches V + 200
    check_val("timer_irq cycle", 32'(t0 + 201), 32'(cycle_cnt));
    bus_write(make_addr(`SLV_CLINT, CLINT_MTIMECMP_HI), 32'h1, 4'hf);
    @(negedge clk);
    check_val("timer_irq hold", 32'd1, 32'(timer_irq));
    @(negedge clk);
    check_val("timer_irq clear", 32'd0, 32'(timer_irq));
  endtask

  task automatic byte_strobes();
    logic [`PERIPH_ADDR_W-1:0] cmp_lo;
    logic [31:0] w1;
    logic [31:0] w2;
    logic [31:0] d;
    cmp_lo = make_addr(`SLV_CLINT, CLINT_MTIMECMP_LO);
    w1 = $urandom;
    w2 = $urandom;
    bus_write(cmp_lo, w1, 4'hf);
    bus_write(cmp_lo, w2, 4'b0101);
    bus_read(cmp_lo, d);
    check_val("byte strobes", {w1[31:24], w2[23:16], w1[15:8], w2[7:0]}, d);
  endtask

  task automatic slot_decode();
    iob_req_t req;
    logic [31:0] d;
    bus_read(make_addr(2, 8'h00), d);
    check_val("slot 2", 32'h0, d);
    bus_read(make_addr(3, 8'h10), d);
    check_val("slot 3", 32'h0, d);
    // Back-to-back reads across two slaves
    req        = '0;
    req.avalid = 1'b1;
    req.addr   = make_addr(`SLV_BOOT_CTR, 8'h00);
    @(posedge clk);
    bus_req <= req;
    @(negedge clk);
    assert (bus_resp.ready === 1'b1) else report_problem("decode: boot_ctr read not ready");
    req.addr = make_addr(`SLV_CLINT, CLINT_MSIP);
    @(posedge clk);
    bus_req <= req;
    @(negedge clk);
    assert (bus_resp.rvalid === 1'b1) else report_problem("decode: first rvalid missing");
    check_val("b2b ctrl", 32'h1, bus_resp.rdata);
    @(posedge clk);
    bus_req <= '0;
    @(negedge clk);
    assert (bus_resp.rvalid === 1'b1) else report_problem("decode: second rvalid missing");
    check_val("b2b msip", 32'h0, bus_resp.rdata);
  endtask

  initial begin
    void'($urandom(32'h45a2_861a));
    arst_n  = 1'b0;
    bus_req = '0;
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    reset_values();
    boot_control();
    soft_interrupt();
    timer_compare();
    byte_strobes();
    slot_decode();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: src/periph_sys.sv
`timescale 1ns/1ps
`default_nettype none

`include "periph_params.svh"

module periph_sys
  import periph_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  iob_req_t  bus_req_i,
  output iob_resp_t bus_resp_o,
  output logic      boot_o,
  output logic      cpu_reset_o,
  output logic      timer_irq_o,
  output logic      soft_irq_o
);

  localparam logic [N_SLOTS-1:0] SlotMap =
    N_SLOTS'((1 << `SLV_BOOT_CTR) | (1 << `SLV_CLINT));

  wire iob_req_t  [N_SLOTS-1:0] slv_req;
  wire iob_resp_t [N_SLOTS-1:0] slv_resp;

  logic [63:0] mtime;
  logic        load;
  logic        load_hi;
  logic [31:0] load_data;
  logic [3:0]  load_strb;

  iob_split #(
    .SLOT_MAP(SlotMap)
  ) i_iob_split (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .m_req_i (bus_req_i),
    .m_resp_o(bus_resp_o),
    .s_req_o (slv_req),
    .s_resp_i(slv_resp)
  );

  // Empty slots are answered inside the split
  for (genvar i = 0; i < N_SLOTS; i++) begin : g_slot
    if (!SlotMap[i]) begin : g_tie
      assign slv_resp[i] = '0;
    end
  end

  boot_ctr i_boot_ctr (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .iob_req_i  (slv_req[`SLV_BOOT_CTR]),
    .iob_resp_o (slv_resp[`SLV_BOOT_CTR]),
    .boot_o     (boot_o),
    .cpu_reset_o(cpu_reset_o)
  );

  clint_regs i_clint_regs (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .iob_req_i  (slv_req[`SLV_CLINT]),
    .iob_resp_o (slv_resp[`SLV_CLINT]),
    .mtime_i    (mtime),
    .load_o     (load),
    .load_hi_o  (load_hi),
    .load_data_o(load_data),
    .load_strb_o(load_strb),
    .timer_irq_o(timer_irq_o),
    .soft_irq_o (soft_irq_o)
  );

  clint_timer i_clint_timer (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .load_i     (load),
    .load_hi_i  (load_hi),
    .load_data_i(load_data),
    .load_strb_i(load_strb),
    .mtime_o    (mtime)
  );

endmodule

`default_nettype wire

// File: clint/clint_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "periph_params.svh"

module clint_regs
  import periph_pkg::*;
(
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  iob_req_t    iob_req_i,
  output iob_resp_t   iob_resp_o,
  input  logic [63:0] mtime_i,
  output logic        load_o,
  output logic        load_hi_o,
  output logic [31:0] load_data_o,
  output logic [3:0]  load_strb_o,
  output logic        timer_irq_o,
  output logic        soft_irq_o
);

  localparam int OffsW = `PERIPH_OFFS_W;

  logic [OffsW-1:0] offs;
  logic             wr;
  logic             rd;
  logic             msip_q;
  logic [63:0]      mtimecmp_q;
  logic             timer_irq_q;
  logic [31:0]      rdata_d;
  logic [31:0]      rdata_q;
  logic             rvalid_q;

  assign offs = iob_req_i.addr[OffsW-1:0];
  assign wr   = iob_req_i.avalid && (iob_req_i.wstrb != '0);
  assign rd   = iob_req_i.avalid && (iob_req_i.wstrb == '0);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      msip_q     <= 1'b0;
      mtimecmp_q <= '1;
    end else if (wr) begin
      case (offs)
        CLINT_MSIP: begin
          if (iob_req_i.wstrb[0]) begin
            msip_q <= iob_req_i.wdata[0];
          end
        end
        CLINT_MTIMECMP_LO: begin
          mtimecmp_q[31:0] <= strb_merge(mtimecmp_q[31:0], iob_req_i.wdata,
                                         iob_req_i.wstrb);
        end
        CLINT_MTIMECMP_HI: begin
          mtimecmp_q[63:32] <= strb_merge(mtimecmp_q[63:32], iob_req_i.wdata,
                                          iob_req_i.wstrb);
        end
        default: ;
      endcase
    end
  end

  // mtime writes go to the counter as a load
  assign load_o      = wr && ((offs == CLINT_MTIME_LO) || (offs == CLINT_MTIME_HI));
  assign load_hi_o   = (offs == CLINT_MTIME_HI);
  assign load_data_o = iob_req_i.wdata;
  assign load_strb_o = iob_req_i.wstrb;

  always_comb begin
    case (offs)
      CLINT_MSIP:        rdata_d = {31'b0, msip_q};
      CLINT_MTIMECMP_LO: rdata_d = mtimecmp_q[31:0];
      CLINT_MTIMECMP_HI: rdata_d = mtimecmp_q[63:32];
      CLINT_MTIME_LO:    rdata_d = mtime_i[31:0];
      CLINT_MTIME_HI:    rdata_d = mtime_i[63:32];
      default:           rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rd) begin
      rdata_q <= rdata_d;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q    <= 1'b0;
      timer_irq_q <= 1'b0;
    end else begin
      rvalid_q    <= rd;
      timer_irq_q <= (mtime_i >= mtimecmp_q);
    end
  end

  assign iob_resp_o.rdata  = rdata_q;
  assign iob_resp_o.rvalid = rvalid_q;
  assign iob_resp_o.ready  = 1'b1;

  assign timer_irq_o = timer_irq_q;
  assign soft_irq_o  = msip_q;

endmodule

`default_nettype wire

// File: clint/clint_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "periph_params.svh"

module clint_timer
  import periph_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          load_i,
  input  logic                          load_hi_i,
  input  logic [`PERIPH_DATA_W-1:0]     load_data_i,
  input  logic [`PERIPH_DATA_W/8-1:0]   load_strb_i,
  output logic [63:0]                   mtime_o
);

  logic [63:0] mtime_q;
  logic [63:0] mtime_d;

  // A load replaces the increment for that cycle
  always_comb begin
    mtime_d = mtime_q + 64'd1;
    if (load_i) begin
      mtime_d = mtime_q;
      if (load_hi_i) begin
        mtime_d[63:32] = strb_merge(mtime_q[63:32], load_data_i, load_strb_i);
      end else begin
        mtime_d[31:0] = strb_merge(mtime_q[31:0], load_data_i, load_strb_i);
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mtime_q <= '0;
    end else begin
      mtime_q <= mtime_d;
    end
  end

  assign mtime_o = mtime_q;

endmodule

`default_nettype wire

// File: boot_ctr/boot_ctr.sv
`timescale 1ns/1ps
`default_nettype none

`include "periph_params.svh"

module boot_ctr
  import periph_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  iob_req_t  iob_req_i,
  output iob_resp_t iob_resp_o,
  output logic      boot_o,
  output logic      cpu_reset_o
);

  localparam int OffsW = `PERIPH_OFFS_W;
  localparam int CntW  = $clog2(`CPU_RST_CYCLES + 1);

  logic [OffsW-1:0] offs;
  logic             is_ctrl;
  logic             wr;
  logic             rd;
  logic             boot_q;
  logic [CntW-1:0]  rst_cnt_q;
  logic             rst_active;
  logic [31:0]      rdata_q;
  logic             rvalid_q;

  assign offs    = iob_req_i.addr[OffsW-1:0];
  assign is_ctrl = (offs == '0);
  assign wr      = iob_req_i.avalid && (iob_req_i.wstrb != '0);
  assign rd      = iob_req_i.avalid && (iob_req_i.wstrb == '0);

  assign rst_active = (rst_cnt_q != '0);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      boot_q <= 1'b1;
    end else if (wr && is_ctrl && iob_req_i.wstrb[0]) begin
      boot_q <= iob_req_i.wdata[0];
    end
  end

  // CPU reset pulse, loaded at power-up and on software request
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rst_cnt_q <= CntW'(`CPU_RST_CYCLES);
    end else if (wr && is_ctrl && iob_req_i.wstrb[0] && iob_req_i.wdata[1]) begin
      rst_cnt_q <= CntW'(`CPU_RST_CYCLES);
    end else if (rst_active) begin
      rst_cnt_q <= rst_cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= rd;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd) begin
      rdata_q <= is_ctrl ? {30'b0, rst_active, boot_q} : '0;
    end
  end

  assign iob_resp_o.rdata  = rdata_q;
  assign iob_resp_o.rvalid = rvalid_q;
  assign iob_resp_o.ready  = 1'b1;

  assign boot_o      = boot_q;
  assign cpu_reset_o = rst_active;

endmodule

`default_nettype wire

// File: src/iob_split.sv
`timescale 1ns/1ps
`default_nettype none

`include "periph_params.svh"

module iob_split
  import periph_pkg::*;
#(
  parameter logic [N_SLOTS-1:0] SLOT_MAP = '1
) (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  iob_req_t                  m_req_i,
  output iob_resp_t                 m_resp_o,
  output iob_req_t  [N_SLOTS-1:0]   s_req_o,
  input  iob_resp_t [N_SLOTS-1:0]   s_resp_i
);

  localparam int AddrW = `PERIPH_ADDR_W;
  localparam int SelW  = `PERIPH_SEL_W;

  logic [SelW-1:0] sel;
  logic            m_ready;
  logic            rd_accept;
  logic [SelW-1:0] rd_sel_q;
  logic            unmapped_rvalid_q;

  assign sel = m_req_i.addr[AddrW-1 -: SelW];

  // Request fans out, avalid only to the addressed slot
  always_comb begin
    for (int i = 0; i < N_SLOTS; i++) begin
      s_req_o[i]        = m_req_i;
      s_req_o[i].avalid = m_req_i.avalid && (sel == SelW'(i));
    end
  end

  // Unmapped slots accept at once
  assign m_ready   = SLOT_MAP[sel] ? s_resp_i[sel].ready : 1'b1;
  assign rd_accept = m_req_i.avalid && m_ready && (m_req_i.wstrb == '0);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_sel_q          <= '0;
      unmapped_rvalid_q <= 1'b0;
    end else begin
      if (rd_accept) begin
        rd_sel_q <= sel;
      end
      unmapped_rvalid_q <= rd_accept && !SLOT_MAP[sel];
    end
  end

  // Response from the slot that took the last read
  always_comb begin
    m_resp_o.ready = m_ready;
    if (SLOT_MAP[rd_sel_q]) begin
      m_resp_o.rdata  = s_resp_i[rd_sel_q].rdata;
      m_resp_o.rvalid = s_resp_i[rd_sel_q].rvalid;
    end else begin
      m_resp_o.rdata  = '0;
      m_resp_o.rvalid = unmapped_rvalid_q;
    end
  end

endmodule

`default_nettype wire

// File: common/periph_pkg.sv
`default_nettype none

`include "periph_params.svh"

package periph_pkg;

  localparam int N_SLOTS = 2 ** `PERIPH_SEL_W;

  // One IOb request beat
  typedef struct packed {
    logic                         avalid;
    logic [`PERIPH_ADDR_W-1:0]    addr;
    logic [`PERIPH_DATA_W-1:0]    wdata;
    logic [`PERIPH_DATA_W/8-1:0]  wstrb;
  } iob_req_t;

  // One IOb response
  typedef struct packed {
    logic [`PERIPH_DATA_W-1:0] rdata;
    logic                      rvalid;
    logic                      ready;
  } iob_resp_t;

  // CLINT register offsets
  localparam logic [`PERIPH_OFFS_W-1:0] CLINT_MSIP        = 8'h00;
  localparam logic [`PERIPH_OFFS_W-1:0] CLINT_MTIMECMP_LO = 8'h08;
  localparam logic [`PERIPH_OFFS_W-1:0] CLINT_MTIMECMP_HI = 8'h0C;
  localparam logic [`PERIPH_OFFS_W-1:0] CLINT_MTIME_LO    = 8'h10;
  localparam logic [`PERIPH_OFFS_W-1:0] CLINT_MTIME_HI    = 8'h14;

  // Byte-enabled merge of a new word into an old one
  function automatic logic [`PERIPH_DATA_W-1:0] strb_merge(
    input logic [`PERIPH_DATA_W-1:0]   old_word,
    input logic [`PERIPH_DATA_W-1:0]   new_word,
    input logic [`PERIPH_DATA_W/8-1:0] strb
  );
    logic [`PERIPH_DATA_W-1:0] merged;
    merged = old_word;
    for (int b = 0; b < `PERIPH_DATA_W / 8; b++) begin
      if (strb[b]) begin
        merged[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return merged;
  endfunction

endpackage

`default_nettype wire

// File: common/periph_params.svh
`ifndef PERIPH_PARAMS_SVH
`define PERIPH_PARAMS_SVH

// Bus geometry
`define PERIPH_ADDR_W 16
`define PERIPH_DATA_W 32

// Top address bits that pick a slave slot
`define PERIPH_SEL_W 2

// Register offset width inside one slot
`define PERIPH_OFFS_W 8

// Slot map
`define SLV_BOOT_CTR 0
`define SLV_CLINT 1

// CPU reset pulse length in clock cycles
`define CPU_RST_CYCLES 16

`endif
